//--- design/backend_macros.svh
`ifndef BACKEND_MACROS_SVH
`define BACKEND_MACROS_SVH

`default_nettype none

// architectural register file
`define BE_NUM_REGS 32
`define BE_REG_ADDR_W 5

// datapath word and pc width
`define BE_DATA_W 32

// retired instruction counter
`define BE_CNT_W 64

`default_nettype wire

`endif

//--- design/backend_pkg.sv
`include "backend_macros.svh"
`default_nettype none

package backend_pkg;

    typedef logic [`BE_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`BE_DATA_W-1:0] bus32_t;
    typedef logic [`BE_CNT_W-1:0] bus64_t;

    // debug write enable, one bit per byte
    typedef logic [3:0] wb_strb_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_LU12I
    } alu_op_t;

endpackage

`default_nettype wire

//--- design/regfile.sv
`timescale 1ns/1ps
`include "backend_macros.svh"
`default_nettype none

module regfile (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  we0_i,
    input  logic                  we1_i,
    input  backend_pkg::reg_addr_t waddr0_i,
    input  backend_pkg::reg_addr_t waddr1_i,
    input  backend_pkg::bus32_t    wdata0_i,
    input  backend_pkg::bus32_t    wdata1_i,
    input  backend_pkg::reg_addr_t raddr0_i,
    input  backend_pkg::reg_addr_t raddr1_i,
    input  backend_pkg::reg_addr_t raddr2_i,
    input  backend_pkg::reg_addr_t raddr3_i,
    output backend_pkg::bus32_t    rdata0_o,
    output backend_pkg::bus32_t    rdata1_o,
    output backend_pkg::bus32_t    rdata2_o,
    output backend_pkg::bus32_t    rdata3_o
);
    import backend_pkg::*;

    bus32_t regs [`BE_NUM_REGS];

    // r0 always reads as zero
    function automatic bus32_t rd_port(input reg_addr_t addr);
        return (addr == '0) ? '0 : regs[addr];
    endfunction

    // write addresses never collide, commit unit resolves that
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `BE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0_i) begin
                regs[waddr0_i] <= wdata0_i;
            end
            if (we1_i) begin
                regs[waddr1_i] <= wdata1_i;
            end
        end
    end

    always_comb begin
        rdata0_o = rd_port(raddr0_i);
        rdata1_o = rd_port(raddr1_i);
        rdata2_o = rd_port(raddr2_i);
        rdata3_o = rd_port(raddr3_i);
    end

endmodule

`default_nettype wire

//--- design/alu_lane.sv
`timescale 1ns/1ps
`default_nettype none

module alu_lane (
    input  logic                   clk,
    input  logic                   rst_i,

    // issued operation
    input  logic                   valid_i,
    input  backend_pkg::alu_op_t   op_i,
    input  backend_pkg::reg_addr_t rj_i,
    input  backend_pkg::reg_addr_t rk_i,
    input  backend_pkg::reg_addr_t rd_i,
    input  backend_pkg::bus32_t    imm_i,
    input  logic                   use_imm_i,
    input  backend_pkg::bus32_t    pc_i,

    // register file read data
    input  backend_pkg::bus32_t    rj_data_i,
    input  backend_pkg::bus32_t    rk_data_i,

    // pending writeback from the commit unit
    input  logic                   fwd_we0_i,
    input  logic                   fwd_we1_i,
    input  backend_pkg::reg_addr_t fwd_addr0_i,
    input  backend_pkg::reg_addr_t fwd_addr1_i,
    input  backend_pkg::bus32_t    fwd_data0_i,
    input  backend_pkg::bus32_t    fwd_data1_i,

    // registered stage
    output logic                   stage_valid_o,
    output backend_pkg::reg_addr_t stage_rd_o,
    output backend_pkg::bus32_t    stage_data_o,
    output backend_pkg::bus32_t    stage_pc_o
);
    import backend_pkg::*;

    bus32_t src_a;
    bus32_t src_b;
    bus32_t rk_val;
    bus32_t result;

    // lane 1 checked last so it wins on a double match
    function automatic bus32_t fwd_sel(input reg_addr_t addr, input bus32_t rf_data);
        bus32_t sel;
        sel = rf_data;
        if (fwd_we0_i && (fwd_addr0_i == addr)) begin
            sel = fwd_data0_i;
        end
        if (fwd_we1_i && (fwd_addr1_i == addr)) begin
            sel = fwd_data1_i;
        end
        return sel;
    endfunction

    always_comb begin
        src_a  = fwd_sel(rj_i, rj_data_i);
        rk_val = fwd_sel(rk_i, rk_data_i);
    end

    assign src_b  = use_imm_i ? imm_i : rk_val;

    always_comb begin
        case (op_i)
            ALU_ADD:   result = src_a + src_b;
            ALU_SUB:   result = src_a - src_b;
            ALU_AND:   result = src_a & src_b;
            ALU_OR:    result = src_a | src_b;
            ALU_XOR:   result = src_a ^ src_b;
            ALU_NOR:   result = ~(src_a | src_b);
            // shift amount from low 5 bits
            ALU_SLL:   result = src_a << src_b[4:0];
            ALU_SRL:   result = src_a >> src_b[4:0];
            ALU_SRA:   result = bus32_t'($signed(src_a) >>> src_b[4:0]);
            ALU_SLT:   result = bus32_t'($signed(src_a) < $signed(src_b));
            ALU_SLTU:  result = bus32_t'(src_a < src_b);
            ALU_LU12I: result = imm_i << 12;
            default:   result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            stage_valid_o <= 1'b0;
        end else begin
            stage_valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        stage_rd_o   <= rd_i;
        stage_data_o <= result;
        stage_pc_o   <= pc_i;
    end

endmodule

`default_nettype wire

//--- design/commit_unit.sv
`timescale 1ns/1ps
`include "backend_macros.svh"
`default_nettype none

module commit_unit (
    input  logic                   clk,
    input  logic                   rst_i,

    // lane stages
    input  logic                   s0_valid_i,
    input  backend_pkg::reg_addr_t s0_rd_i,
    input  backend_pkg::bus32_t    s0_data_i,
    input  backend_pkg::bus32_t    s0_pc_i,
    input  logic                   s1_valid_i,
    input  backend_pkg::reg_addr_t s1_rd_i,
    input  backend_pkg::bus32_t    s1_data_i,
    input  backend_pkg::bus32_t    s1_pc_i,

    // register file writes, also the forwarding source
    output logic                   reg_we0_o,
    output logic                   reg_we1_o,
    output backend_pkg::reg_addr_t reg_waddr0_o,
    output backend_pkg::reg_addr_t reg_waddr1_o,
    output backend_pkg::bus32_t    reg_wdata0_o,
    output backend_pkg::bus32_t    reg_wdata1_o,

    // debug writeback
    output backend_pkg::bus32_t    debug_wb_pc0_o,
    output backend_pkg::bus32_t    debug_wb_pc1_o,
    output backend_pkg::wb_strb_t  debug_wb_rf_wen0_o,
    output backend_pkg::wb_strb_t  debug_wb_rf_wen1_o,
    output backend_pkg::reg_addr_t debug_wb_rf_wnum0_o,
    output backend_pkg::reg_addr_t debug_wb_rf_wnum1_o,
    output backend_pkg::bus32_t    debug_wb_rf_wdata0_o,
    output backend_pkg::bus32_t    debug_wb_rf_wdata1_o,
    output logic                   inst_valid0_o,
    output logic                   inst_valid1_o,
    output backend_pkg::bus64_t    retire_cnt_o
);
    import backend_pkg::*;

    // lane 1 is younger, it wins a shared destination
    assign reg_we1_o = s1_valid_i && (s1_rd_i != '0);
    assign reg_we0_o = s0_valid_i && (s0_rd_i != '0) &&
                       !(reg_we1_o && (s1_rd_i == s0_rd_i));

    assign reg_waddr0_o = s0_rd_i;
    assign reg_waddr1_o = s1_rd_i;
    assign reg_wdata0_o = s0_data_i;
    assign reg_wdata1_o = s1_data_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            debug_wb_rf_wen0_o <= '0;
            debug_wb_rf_wen1_o <= '0;
            inst_valid0_o      <= 1'b0;
            inst_valid1_o      <= 1'b0;
            retire_cnt_o       <= '0;
        end else begin
            debug_wb_rf_wen0_o <= {$bits(wb_strb_t){reg_we0_o}};
            debug_wb_rf_wen1_o <= {$bits(wb_strb_t){reg_we1_o}};
            inst_valid0_o      <= s0_valid_i;
            inst_valid1_o      <= s1_valid_i;
            retire_cnt_o       <= retire_cnt_o
                                  + {{(`BE_CNT_W-1){1'b0}}, s0_valid_i}
                                  + {{(`BE_CNT_W-1){1'b0}}, s1_valid_i};
        end
    end

    always_ff @(posedge clk) begin
        debug_wb_rf_wnum0_o  <= reg_waddr0_o;
        debug_wb_rf_wnum1_o  <= reg_waddr1_o;
        debug_wb_rf_wdata0_o <= reg_wdata0_o;
        debug_wb_rf_wdata1_o <= reg_wdata1_o;
        // pc holds the last valid op
        if (s0_valid_i) begin
            debug_wb_pc0_o <= s0_pc_i;
        end
        if (s1_valid_i) begin
            debug_wb_pc1_o <= s1_pc_i;
        end
    end

endmodule

`default_nettype wire

//--- design/backend_top.sv
`timescale 1ns/1ps
`default_nettype none

module backend_top (
    input  logic                   clk,
    input  logic                   rst_i,

    // lane 0 issue
    input  logic                   inst_valid_0_i,
    input  backend_pkg::alu_op_t   op_0_i,
    input  backend_pkg::reg_addr_t rj_0_i,
    input  backend_pkg::reg_addr_t rk_0_i,
    input  backend_pkg::reg_addr_t rd_0_i,
    input  backend_pkg::bus32_t    imm_0_i,
    input  logic                   use_imm_0_i,
    input  backend_pkg::bus32_t    pc_0_i,

    // lane 1 issue
    input  logic                   inst_valid_1_i,
    input  backend_pkg::alu_op_t   op_1_i,
    input  backend_pkg::reg_addr_t rj_1_i,
    input  backend_pkg::reg_addr_t rk_1_i,
    input  backend_pkg::reg_addr_t rd_1_i,
    input  backend_pkg::bus32_t    imm_1_i,
    input  logic                   use_imm_1_i,
    input  backend_pkg::bus32_t    pc_1_i,

    // debug
    output backend_pkg::bus32_t    debug_wb_pc0_o,
    output backend_pkg::bus32_t    debug_wb_pc1_o,
    output backend_pkg::wb_strb_t  debug_wb_rf_wen0_o,
    output backend_pkg::wb_strb_t  debug_wb_rf_wen1_o,
    output backend_pkg::reg_addr_t debug_wb_rf_wnum0_o,
    output backend_pkg::reg_addr_t debug_wb_rf_wnum1_o,
    output backend_pkg::bus32_t    debug_wb_rf_wdata0_o,
    output backend_pkg::bus32_t    debug_wb_rf_wdata1_o,
    output logic                   inst_valid0_o,
    output logic                   inst_valid1_o,
    output backend_pkg::bus64_t    retire_cnt_o
);
    import backend_pkg::*;

    bus32_t    rj_data_0;
    bus32_t    rk_data_0;
    bus32_t    rj_data_1;
    bus32_t    rk_data_1;

    logic      stage_valid_0;
    reg_addr_t stage_rd_0;
    bus32_t    stage_data_0;
    bus32_t    stage_pc_0;
    logic      stage_valid_1;
    reg_addr_t stage_rd_1;
    bus32_t    stage_data_1;
    bus32_t    stage_pc_1;

    // commit writes, shared by regfile and forwarding
    logic      reg_we0;
    logic      reg_we1;
    reg_addr_t reg_waddr0;
    reg_addr_t reg_waddr1;
    bus32_t    reg_wdata0;
    bus32_t    reg_wdata1;

    regfile u_regfile (
        .clk      (clk),
        .rst_i    (rst_i),
        .we0_i    (reg_we0),
        .we1_i    (reg_we1),
        .waddr0_i (reg_waddr0),
        .waddr1_i (reg_waddr1),
        .wdata0_i (reg_wdata0),
        .wdata1_i (reg_wdata1),
        .raddr0_i (rj_0_i),
        .raddr1_i (rk_0_i),
        .raddr2_i (rj_1_i),
        .raddr3_i (rk_1_i),
        .rdata0_o (rj_data_0),
        .rdata1_o (rk_data_0),
        .rdata2_o (rj_data_1),
        .rdata3_o (rk_data_1)
    );

    alu_lane u_lane0 (
        .clk           (clk),
        .rst_i         (rst_i),
        .valid_i       (inst_valid_0_i),
        .op_i          (op_0_i),
        .rj_i          (rj_0_i),
        .rk_i          (rk_0_i),
        .rd_i          (rd_0_i),
        .imm_i         (imm_0_i),
        .use_imm_i     (use_imm_0_i),
        .pc_i          (pc_0_i),
        .rj_data_i     (rj_data_0),
        .rk_data_i     (rk_data_0),
        .fwd_we0_i     (reg_we0),
        .fwd_we1_i     (reg_we1),
        .fwd_addr0_i   (reg_waddr0),
        .fwd_addr1_i   (reg_waddr1),
        .fwd_data0_i   (reg_wdata0),
        .fwd_data1_i   (reg_wdata1),
        .stage_valid_o (stage_valid_0),
        .stage_rd_o    (stage_rd_0),
        .stage_data_o  (stage_data_0),
        .stage_pc_o    (stage_pc_0)
    );

    alu_lane u_lane1 (
        .clk           (clk),
        .rst_i         (rst_i),
        .valid_i       (inst_valid_1_i),
        .op_i          (op_1_i),
        .rj_i          (rj_1_i),
        .rk_i          (rk_1_i),
        .rd_i          (rd_1_i),
        .imm_i         (imm_1_i),
        .use_imm_i     (use_imm_1_i),
        .pc_i          (pc_1_i),
        .rj_data_i     (rj_data_1),
        .rk_data_i     (rk_data_1),
        .fwd_we0_i     (reg_we0),
        .fwd_we1_i     (reg_we1),
        .fwd_addr0_i   (reg_waddr0),
        .fwd_addr1_i   (reg_waddr1),
        .fwd_data0_i   (reg_wdata0),
        .fwd_data1_i   (reg_wdata1),
        .stage_valid_o (stage_valid_1),
        .stage_rd_o    (stage_rd_1),
        .stage_data_o  (stage_data_1),
        .stage_pc_o    (stage_pc_1)
    );

    commit_unit u_commit (
        .clk                  (clk),
        .rst_i                (rst_i),
        .s0_valid_i           (stage_valid_0),
        .s0_rd_i              (stage_rd_0),
        .s0_data_i            (stage_data_0),
        .s0_pc_i              (stage_pc_0),
        .s1_valid_i           (stage_valid_1),
        .s1_rd_i              (stage_rd_1),
        .s1_data_i            (stage_data_1),
        .s1_pc_i              (stage_pc_1),
        .reg_we0_o            (reg_we0),
        .reg_we1_o            (reg_we1),
        .reg_waddr0_o         (reg_waddr0),
        .reg_waddr1_o         (reg_waddr1),
        .reg_wdata0_o         (reg_wdata0),
        .reg_wdata1_o         (reg_wdata1),
        .debug_wb_pc0_o       (debug_wb_pc0_o),
        .debug_wb_pc1_o       (debug_wb_pc1_o),
        .debug_wb_rf_wen0_o   (debug_wb_rf_wen0_o),
        .debug_wb_rf_wen1_o   (debug_wb_rf_wen1_o),
        .debug_wb_rf_wnum0_o  (debug_wb_rf_wnum0_o),
        .debug_wb_rf_wnum1_o  (debug_wb_rf_wnum1_o),
        .debug_wb_rf_wdata0_o (debug_wb_rf_wdata0_o),
        .debug_wb_rf_wdata1_o (debug_wb_rf_wdata1_o),
        .inst_valid0_o        (inst_valid0_o),
        .inst_valid1_o        (inst_valid1_o),
        .retire_cnt_o         (retire_cnt_o)
    );

endmodule

`default_nettype wire

//--- sim/backend_chk.sv
`timescale 1ns/1ps
`default_nettype none

module backend_chk (
    input logic                   clk,
    input logic                   rst_i,
    input logic                   we0_i,
    input logic                   we1_i,
    input backend_pkg::reg_addr_t waddr0_i,
    input backend_pkg::reg_addr_t waddr1_i,
    input backend_pkg::wb_strb_t  wen0_i,
    input backend_pkg::wb_strb_t  wen1_i,
    input logic                   stage_valid0_i,
    input logic                   stage_valid1_i
);
    int fail_cnt = 0;

    // both ports enabled on one register
    a_no_collide: assert property (@(posedge clk) disable iff (rst_i)
        !(we0_i && we1_i && (waddr0_i == waddr1_i)))
        else begin
            fail_cnt++;
            $error("register write ports share an address");
        end

    a_no_r0_write: assert property (@(posedge clk) disable iff (rst_i)
        !((we0_i && (waddr0_i == '0)) || (we1_i && (waddr1_i == '0))))
        else begin
            fail_cnt++;
            $error("register write to r0");
        end

    // wen is a full nibble or nothing
    a_wen_form: assert property (@(posedge clk) disable iff (rst_i)
        ((wen0_i == '0) || (wen0_i == '1)) && ((wen1_i == '0) || (wen1_i == '1)))
        else begin
            fail_cnt++;
            $error("debug wen is partly set");
        end

    a_reset_clear: assert property (@(posedge clk)
        rst_i |=> !(stage_valid0_i || stage_valid1_i))
        else begin
            fail_cnt++;
            $error("stage valid right after reset");
        end

endmodule

bind backend_top backend_chk u_chk (
    .clk            (clk),
    .rst_i          (rst_i),
    .we0_i          (reg_we0),
    .we1_i          (reg_we1),
    .waddr0_i       (reg_waddr0),
    .waddr1_i       (reg_waddr1),
    .wen0_i         (debug_wb_rf_wen0_o),
    .wen1_i         (debug_wb_rf_wen1_o),
    .stage_valid0_i (stage_valid_0),
    .stage_valid1_i (stage_valid_1)
);

`default_nettype wire

//--- sim/backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module backend_tb;
    import backend_pkg::*;

    // one lane of a bundle plus its expected writeback
    typedef struct packed {
        logic      valid;
        alu_op_t   op;
        reg_addr_t rj;
        reg_addr_t rk;
        reg_addr_t rd;
        bus32_t    imm;
        logic      use_imm;
        bus32_t    pc;
        wb_strb_t  exp_wen;
        bus32_t    exp_data;
    } lane_rec_t;

    typedef struct packed {
        int        due;
        lane_rec_t l0;
        lane_rec_t l1;
    } exp_rec_t;

    logic      clk;
    logic      rst_i;
    lane_rec_t drv0;
    lane_rec_t drv1;

    bus32_t    wb_pc0;
    bus32_t    wb_pc1;
    wb_strb_t  wen0;
    wb_strb_t  wen1;
    reg_addr_t wnum0;
    reg_addr_t wnum1;
    bus32_t    wdata0;
    bus32_t    wdata1;
    logic      iv0;
    logic      iv1;
    bus64_t    retire_cnt;

    logic [31:0] fld [21];
    int          gap_q[$];
    lane_rec_t   bnd0_q[$];
    lane_rec_t   bnd1_q[$];
    exp_rec_t    exp_q[$];
    int          neg_cnt = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    int          gap_total = 0;
    int          valid_total = 0;

    backend_top dut0 (
        .clk                  (clk),
        .rst_i                (rst_i),
        .inst_valid_0_i       (drv0.valid),
        .op_0_i               (drv0.op),
        .rj_0_i               (drv0.rj),
        .rk_0_i               (drv0.rk),
        .rd_0_i               (drv0.rd),
        .imm_0_i              (drv0.imm),
        .use_imm_0_i          (drv0.use_imm),
        .pc_0_i               (drv0.pc),
        .inst_valid_1_i       (drv1.valid),
        .op_1_i               (drv1.op),
        .rj_1_i               (drv1.rj),
        .rk_1_i               (drv1.rk),
        .rd_1_i               (drv1.rd),
        .imm_1_i              (drv1.imm),
        .use_imm_1_i          (drv1.use_imm),
        .pc_1_i               (drv1.pc),
        .debug_wb_pc0_o       (wb_pc0),
        .debug_wb_pc1_o       (wb_pc1),
        .debug_wb_rf_wen0_o   (wen0),
        .debug_wb_rf_wen1_o   (wen1),
        .debug_wb_rf_wnum0_o  (wnum0),
        .debug_wb_rf_wnum1_o  (wnum1),
        .debug_wb_rf_wdata0_o (wdata0),
        .debug_wb_rf_wdata1_o (wdata1),
        .inst_valid0_o        (iv0),
        .inst_valid1_o        (iv1),
        .retire_cnt_o         (retire_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string what, input bus32_t got, input bus32_t exp);
        if (got !== exp) begin
            fail_now($sformatf("[ERROR] %0t %s: got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            fail_now($sformatf("[ERROR] %0t %s: got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_strb(input string what, input wb_strb_t got, input wb_strb_t exp);
        if (got !== exp) begin
            fail_now($sformatf("[ERROR] %0t %s: got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_count(input string what, input bus64_t got, input bus64_t exp);
        if (got !== exp) begin
            fail_now($sformatf("[ERROR] %0t %s: got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("[ERROR] %0t %s: got %b expected %b", $time, what, got, exp));
        end
    endtask

    // b is the first stimulus field of the lane, e its expected wen
    function automatic lane_rec_t make_lane(input int b, input int e);
        lane_rec_t r;
        r.valid    = fld[b][0];
        r.op       = alu_op_t'(fld[b+1][3:0]);
        r.rj       = reg_addr_t'(fld[b+2]);
        r.rk       = reg_addr_t'(fld[b+3]);
        r.rd       = reg_addr_t'(fld[b+4]);
        r.imm      = fld[b+5];
        r.use_imm  = fld[b+6][0];
        r.pc       = fld[b+7];
        r.exp_wen  = wb_strb_t'(fld[e]);
        r.exp_data = fld[e+1];
        return r;
    endfunction

    task automatic load_bundles();
        int    fd;
        int    n;
        string line;
        fd = $fopen("sim/backend_input.txt", "r");
        if (fd == 0) begin
            fail_now("cannot open sim/backend_input.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                        fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                        fld[14], fld[15], fld[16], fld[17], fld[18], fld[19], fld[20]);
            if (n != 21) begin
                fail_now($sformatf("bad line in input file: %s", line));
            end
            gap_q.push_back(int'(fld[0]));
            bnd0_q.push_back(make_lane(1, 17));
            bnd1_q.push_back(make_lane(9, 19));
        end
        $fclose(fd);
    endtask

    task automatic check_lane(input int lane, input lane_rec_t e, input logic iv,
                              input wb_strb_t wen, input reg_addr_t wnum,
                              input bus32_t wdata, input bus32_t pc);
        string tag;
        tag = $sformatf("lane%0d", lane);
        check_flag({tag, " inst_valid"}, iv, e.valid);
        check_strb({tag, " wen"}, wen, e.exp_wen);
        if (e.valid) begin
            check_addr({tag, " wnum"}, wnum, e.rd);
            check_word({tag, " wdata"}, wdata, e.exp_data);
            check_word({tag, " pc"}, pc, e.pc);
        end
    endtask

    // debug ports show a bundle two falling edges after it was driven
    task automatic next_cycle();
        exp_rec_t e;
        @(negedge clk);
        neg_cnt++;
        if (exp_q.size() != 0 && exp_q[0].due == neg_cnt) begin
            e = exp_q.pop_front();
            check_lane(0, e.l0, iv0, wen0, wnum0, wdata0, wb_pc0);
            check_lane(1, e.l1, iv1, wen1, wnum1, wdata1, wb_pc1);
        end else begin
            // idle or reset slot retires nothing
            check_flag("lane0 idle inst_valid", iv0, 1'b0);
            check_flag("lane1 idle inst_valid", iv1, 1'b0);
            check_strb("lane0 idle wen", wen0, '0);
            check_strb("lane1 idle wen", wen1, '0);
        end
        drv0 = '0;
        drv1 = '0;
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
            fail_now($sformatf("timeout after %0d cycles, limit %0d", cycle_cnt, cycle_limit));
        end
    end

    initial begin
        exp_rec_t er;
        rst_i = 1'b1;
        drv0  = '0;
        drv1  = '0;
        load_bundles();
        foreach (gap_q[i]) begin
            gap_total   += gap_q[i];
            valid_total += int'(bnd0_q[i].valid) + int'(bnd1_q[i].valid);
        end
        cycle_limit = gap_total + gap_q.size() + 20;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        foreach (gap_q[i]) begin
            repeat (gap_q[i]) next_cycle();
            next_cycle();
            drv0 = bnd0_q[i];
            drv1 = bnd1_q[i];
            er.due = neg_cnt + 2;
            er.l0  = bnd0_q[i];
            er.l1  = bnd1_q[i];
            exp_q.push_back(er);
        end
        while (exp_q.size() != 0) begin
            next_cycle();
        end

        check_count("retire_cnt", retire_cnt, bus64_t'(valid_total));
        if (dut0.u_chk.fail_cnt != 0) begin
            fail_now("assertion failures in the checker");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/backend_input.txt
# fields (hex): gap | lane0 v op rj rk rd imm use_imm pc | lane1 v op rj rk rd imm use_imm pc
# then the expected debug writeback: wen0 wdata0 wen1 wdata1
0 1 0 00 00 01 12345678 1 1c000000 1 b 00 00 02 000fffff 1 1c000004 f 12345678 f fffff000
0 1 1 01 02 03 00000000 0 1c000008 1 2 01 00 04 0000ff0f 1 1c00000c f 12346678 f 00005608
2 1 3 02 04 05 00000000 0 1c000010 1 4 01 03 06 00000000 0 1c000014 f fffff608 f 00003000
1 1 5 00 04 07 00000000 0 1c000018 1 6 01 00 08 00000004 1 1c00001c f ffffa9f7 f 23456780
0 1 7 02 00 09 00000008 1 1c000020 1 8 07 00 0a 00000024 1 1c000024 f 00fffff0 f fffffa9f
0 1 9 07 01 0b 00000000 0 1c000028 1 a 07 01 0c 00000000 0 1c00002c f 00000001 f 00000000
0 1 6 06 04 0d 00000000 0 1c000030 1 a 0b 00 0e 00000002 1 1c000034 f 00300000 f 00000001
1 1 0 00 00 0f 11111111 1 1c000038 1 0 00 00 0f 22222222 1 1c00003c 0 11111111 f 22222222
0 1 0 0f 00 10 00000001 1 1c000040 1 3 0f 00 11 00000000 0 1c000044 f 22222223 f 22222222
2 1 4 0f 00 12 33333333 1 1c000048 1 0 01 00 00 00000005 1 1c00004c f 11111111 0 1234567d
0 1 0 00 00 13 00000007 1 1c000050 0 0 00 00 00 00000000 0 00000000 f 00000007 0 00000000
3 0 0 00 00 00 00000000 0 00000000 1 1 00 12 14 00000000 0 1c000058 0 00000000 f eeeeeeef
0 1 9 14 00 15 00000000 1 1c00005c 0 0 00 00 00 00000000 0 00000000 f 00000001 0 00000000
1 1 a 00 01 16 00000000 0 1c000060 1 8 02 04 17 00000000 0 1c000064 f 00000001 f fffffff0
0 1 2 17 03 18 00000000 0 1c000068 1 5 09 00 19 00000000 1 1c00006c f 12346670 f ff00000f

//--- tb.f
+incdir+design
design/backend_pkg.sv
design/regfile.sv
design/alu_lane.sv
design/commit_unit.sv
design/backend_top.sv
sim/backend_chk.sv
sim/backend_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module backend_tb \
    -o sim_backend || exit 1
out=$(./obj_dir/sim_backend 2>&1)
echo "$out"
echo "$out" | grep -qx "all tests passed" && exit 0 || { echo "simulation did not pass"; exit 1; }
